/* design/muldiv_defines.svh */
`ifndef MULDIV_DEFINES_SVH
`define MULDIV_DEFINES_SVH

// ============================================================
// datapath widths
// ============================================================

`define MULDIV_XLEN 32                     // operand / result width
`define MULDIV_UNROLL 8                    // multiplier bits per stage, divides XLEN

// ============================================================
// tracking widths
// ============================================================

`define MULDIV_TAG_W 6                     // destination tag
`define MULDIV_BRMASK_W 4                  // outstanding branch slots
`define MULDIV_KILL_IDX_W $clog2(`MULDIV_BRMASK_W)

`endif

/* design/muldiv_pkg.sv */
`include "muldiv_defines.svh"

package muldiv_pkg;

  typedef enum logic [3:0] {
    OP_NONE   = 4'h0,
    OP_MUL    = 4'h1,
    OP_MULH   = 4'h2,
    OP_MULHSU = 4'h3,
    OP_MULHU  = 4'h4,
    OP_DIV    = 4'h5,
    OP_DIVU   = 4'h6,
    OP_REM    = 4'h7,
    OP_REMU   = 4'h8
  } op_t;

  typedef enum logic [1:0] {
    DIV_IDLE = 2'd0,
    DIV_BUSY = 2'd1,
    DIV_DONE = 2'd2
  } div_state_t;

  typedef logic [`MULDIV_TAG_W-1:0]    tag_t;
  typedef logic [`MULDIV_BRMASK_W-1:0] brmask_t;

  // op depends on the branch being killed
  function automatic logic is_killed(brmask_t mask, logic kill_valid,
                                     logic [`MULDIV_KILL_IDX_W-1:0] kill_idx);
    return kill_valid & mask[kill_idx];
  endfunction

  function automatic logic is_mul_op(op_t op);
    return op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
  endfunction

  function automatic logic is_div_op(op_t op);
    return op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
  endfunction

  function automatic logic is_mulh_op(op_t op);
    return op inside {OP_MULH, OP_MULHSU, OP_MULHU};   // upper product word
  endfunction

  function automatic logic is_rem_op(op_t op);
    return op inside {OP_REM, OP_REMU};
  endfunction

endpackage

/* design/muldiv_mul_pipe.sv */
`include "muldiv_defines.svh"

module muldiv_mul_pipe (
  input  logic                              i_clk,
  input  logic                              i_reset_n,
  input  logic                              i_valid,
  input  muldiv_pkg::op_t                   i_op,
  input  logic [`MULDIV_XLEN-1:0]           i_rs1,
  input  logic [`MULDIV_XLEN-1:0]           i_rs2,
  input  muldiv_pkg::tag_t                  i_rd_tag,
  input  muldiv_pkg::brmask_t               i_br_mask,
  input  logic                              i_kill_valid,
  input  logic [`MULDIV_KILL_IDX_W-1:0]     i_kill_idx,
  output logic                              o_valid,
  output logic [`MULDIV_XLEN-1:0]           o_res,
  output muldiv_pkg::tag_t                  o_rd_tag
);

  localparam int XLEN      = `MULDIV_XLEN;
  localparam int UNROLL    = `MULDIV_UNROLL;
  localparam int MUL_STEPS = XLEN / UNROLL;
  localparam int PP_W      = XLEN + UNROLL + 2;   // 33b x 9b signed product

  logic                      r_valid [1:MUL_STEPS];
  muldiv_pkg::op_t           r_op    [1:MUL_STEPS];
  logic [XLEN:0]             r_a     [1:MUL_STEPS-1];
  logic [XLEN:0]             r_b     [1:MUL_STEPS-1];
  logic [2*XLEN-1:0]         r_acc   [1:MUL_STEPS];
  muldiv_pkg::tag_t          r_tag   [1:MUL_STEPS];
  muldiv_pkg::brmask_t       r_mask  [1:MUL_STEPS];
  logic                      w_kill  [1:MUL_STEPS];

  logic [XLEN:0]             w_a_ext;
  logic [XLEN:0]             w_b_ext;
  logic [2*XLEN-1:0]         w_acc_next [0:MUL_STEPS-1];

  // rs1 signed for MUL/MULH/MULHSU, rs2 signed for MUL/MULH
  assign w_a_ext = (i_op == muldiv_pkg::OP_MULHU) ? {1'b0, i_rs1}
                                                  : {i_rs1[XLEN-1], i_rs1};
  assign w_b_ext = (i_op == muldiv_pkg::OP_MUL || i_op == muldiv_pkg::OP_MULH) ?
                   {i_rs2[XLEN-1], i_rs2} : {1'b0, i_rs2};

  // ============================================================
  // partial product per stage
  // ============================================================

  for (genvar s = 0; s < MUL_STEPS; s++) begin : g_stage
    logic [XLEN:0]          w_a;
    logic [XLEN:0]          w_b;
    logic [2*XLEN-1:0]      w_acc;
    logic [UNROLL:0]        w_slice;
    logic signed [PP_W-1:0] w_a_x;
    logic signed [PP_W-1:0] w_slice_x;
    logic signed [PP_W-1:0] w_pp;

    if (s == 0) begin : g_head
      assign w_a   = w_a_ext;
      assign w_b   = w_b_ext;
      assign w_acc = '0;
    end else begin : g_body
      assign w_a   = r_a[s];
      assign w_b   = r_b[s];
      assign w_acc = r_acc[s];
    end

    if (s == MUL_STEPS - 1) begin : g_sign_slice
      assign w_slice = w_b[XLEN -: UNROLL+1];             // carries the sign bit
    end else begin : g_plain_slice
      assign w_slice = {1'b0, w_b[s*UNROLL +: UNROLL]};
    end

    assign w_a_x     = {{(PP_W-XLEN-1){w_a[XLEN]}}, w_a};
    assign w_slice_x = {{(PP_W-UNROLL-1){w_slice[UNROLL]}}, w_slice};
    assign w_pp      = w_a_x * w_slice_x;

    assign w_acc_next[s] = w_acc + ({{(2*XLEN-PP_W){w_pp[PP_W-1]}}, w_pp} << (s*UNROLL));
  end

  always_comb begin
    for (int s = 1; s <= MUL_STEPS; s++) begin
      w_kill[s] = muldiv_pkg::is_killed(r_mask[s], i_kill_valid, i_kill_idx);
    end
  end

  // ============================================================
  // stage registers
  // ============================================================

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int s = 1; s <= MUL_STEPS; s++) begin
        r_valid[s] <= 1'b0;
      end
    end else begin
      r_valid[1] <= i_valid;                              // issue kill filtered at top
      for (int s = 2; s <= MUL_STEPS; s++) begin
        r_valid[s] <= r_valid[s-1] & ~w_kill[s-1];
      end
    end
  end

  always_ff @(posedge i_clk) begin
    r_op[1]   <= i_op;
    r_a[1]    <= w_a_ext;
    r_b[1]    <= w_b_ext;
    r_tag[1]  <= i_rd_tag;
    r_mask[1] <= i_br_mask;
    for (int s = 2; s <= MUL_STEPS; s++) begin
      r_op[s]   <= r_op[s-1];
      r_tag[s]  <= r_tag[s-1];
      r_mask[s] <= r_mask[s-1];
    end
    for (int s = 2; s < MUL_STEPS; s++) begin
      r_a[s] <= r_a[s-1];
      r_b[s] <= r_b[s-1];
    end
    for (int s = 1; s <= MUL_STEPS; s++) begin
      r_acc[s] <= w_acc_next[s-1];
    end
  end

  assign o_valid  = r_valid[MUL_STEPS] & ~w_kill[MUL_STEPS];
  assign o_res    = muldiv_pkg::is_mulh_op(r_op[MUL_STEPS]) ? r_acc[MUL_STEPS][2*XLEN-1:XLEN]
                                                            : r_acc[MUL_STEPS][XLEN-1:0];
  assign o_rd_tag = r_tag[MUL_STEPS];

  a_last_stage_is_mul: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    r_valid[MUL_STEPS] |-> muldiv_pkg::is_mul_op(r_op[MUL_STEPS]))
    else $error("non-multiply op reached the multiplier output");

endmodule

/* design/muldiv_div_unit.sv */
`include "muldiv_defines.svh"

module muldiv_div_unit (
  input  logic                              i_clk,
  input  logic                              i_reset_n,
  input  logic                              i_valid,
  input  muldiv_pkg::op_t                   i_op,
  input  logic [`MULDIV_XLEN-1:0]           i_rs1,
  input  logic [`MULDIV_XLEN-1:0]           i_rs2,
  input  muldiv_pkg::tag_t                  i_rd_tag,
  input  muldiv_pkg::brmask_t               i_br_mask,
  input  logic                              i_kill_valid,
  input  logic [`MULDIV_KILL_IDX_W-1:0]     i_kill_idx,
  input  logic                              i_resp_ready,
  output logic                              o_ready,
  output logic                              o_valid,
  output logic [`MULDIV_XLEN-1:0]           o_res,
  output muldiv_pkg::tag_t                  o_rd_tag
);

  localparam int XLEN  = `MULDIV_XLEN;
  localparam int CNT_W = $clog2(XLEN);

  muldiv_pkg::div_state_t r_state;
  logic [CNT_W-1:0]       r_cnt;
  muldiv_pkg::op_t        r_op;
  muldiv_pkg::tag_t       r_tag;
  muldiv_pkg::brmask_t    r_mask;
  logic [XLEN-1:0]        r_quo;      // dividend in, quotient out
  logic [XLEN-1:0]        r_rem;
  logic [XLEN-1:0]        r_dvsr;
  logic                   r_special;
  logic                   r_neg_q;
  logic                   r_neg_r;

  logic                   w_accept;
  logic                   w_kill;
  logic                   w_signed;
  logic                   w_rs1_neg;
  logic                   w_rs2_neg;
  logic [XLEN-1:0]        w_rs1_mag;
  logic [XLEN-1:0]        w_rs2_mag;
  logic                   w_div_zero;
  logic                   w_overflow;
  logic [XLEN:0]          w_shifted;
  logic [XLEN+1:0]        w_trial;
  logic                   w_fits;
  logic [XLEN-1:0]        w_quo_fix;
  logic [XLEN-1:0]        w_rem_fix;

  assign w_accept   = i_valid & (r_state == muldiv_pkg::DIV_IDLE);
  assign w_kill     = muldiv_pkg::is_killed(r_mask, i_kill_valid, i_kill_idx);

  assign w_signed   = (i_op == muldiv_pkg::OP_DIV) | (i_op == muldiv_pkg::OP_REM);
  assign w_rs1_neg  = w_signed & i_rs1[XLEN-1];
  assign w_rs2_neg  = w_signed & i_rs2[XLEN-1];
  assign w_rs1_mag  = w_rs1_neg ? -i_rs1 : i_rs1;
  assign w_rs2_mag  = w_rs2_neg ? -i_rs2 : i_rs2;
  assign w_div_zero = (i_rs2 == '0);
  assign w_overflow = w_signed & (i_rs1 == {1'b1, {(XLEN-1){1'b0}}}) & (&i_rs2);

  // one restoring step
  assign w_shifted = {r_rem, r_quo[XLEN-1]};
  assign w_trial   = {1'b0, w_shifted} - {2'b00, r_dvsr};
  assign w_fits    = ~w_trial[XLEN+1];

  // ============================================================
  // control FSM
  // ============================================================

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= muldiv_pkg::DIV_IDLE;
      r_cnt   <= '0;
    end else begin
      case (r_state)
        muldiv_pkg::DIV_IDLE: begin
          if (w_accept) begin
            r_state <= muldiv_pkg::DIV_BUSY;
            r_cnt   <= CNT_W'(XLEN - 1);
          end
        end
        muldiv_pkg::DIV_BUSY: begin
          if (w_kill) begin
            r_state <= muldiv_pkg::DIV_IDLE;
          end else if (r_special || r_cnt == '0) begin
            r_state <= muldiv_pkg::DIV_DONE;    // special cases leave after one cycle
          end else begin
            r_cnt <= r_cnt - 1'b1;
          end
        end
        muldiv_pkg::DIV_DONE: begin
          if (w_kill || i_resp_ready) begin
            r_state <= muldiv_pkg::DIV_IDLE;
          end
        end
        default: r_state <= muldiv_pkg::DIV_IDLE;
      endcase
    end
  end

  // ============================================================
  // datapath
  // ============================================================

  always_ff @(posedge i_clk) begin
    if (w_accept) begin
      r_op      <= i_op;
      r_tag     <= i_rd_tag;
      r_mask    <= i_br_mask;
      r_dvsr    <= w_rs2_mag;
      r_special <= w_div_zero | w_overflow;
      if (w_div_zero) begin
        r_quo   <= '1;
        r_rem   <= i_rs1;
        r_neg_q <= 1'b0;
        r_neg_r <= 1'b0;
      end else if (w_overflow) begin
        r_quo   <= i_rs1;
        r_rem   <= '0;
        r_neg_q <= 1'b0;
        r_neg_r <= 1'b0;
      end else begin
        r_quo   <= w_rs1_mag;
        r_rem   <= '0;
        r_neg_q <= w_rs1_neg ^ w_rs2_neg;
        r_neg_r <= w_rs1_neg;                 // remainder follows dividend sign
      end
    end else if (r_state == muldiv_pkg::DIV_BUSY && !r_special) begin
      r_rem <= w_fits ? w_trial[XLEN-1:0] : w_shifted[XLEN-1:0];
      r_quo <= {r_quo[XLEN-2:0], w_fits};
    end
  end

  assign w_quo_fix = r_neg_q ? -r_quo : r_quo;
  assign w_rem_fix = r_neg_r ? -r_rem : r_rem;

  assign o_ready  = (r_state == muldiv_pkg::DIV_IDLE);
  assign o_valid  = (r_state == muldiv_pkg::DIV_DONE) & i_resp_ready & ~w_kill;
  assign o_res    = muldiv_pkg::is_rem_op(r_op) ? w_rem_fix : w_quo_fix;
  assign o_rd_tag = r_tag;

  a_valid_only_done: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_valid |-> r_state == muldiv_pkg::DIV_DONE && (r_special || r_rem < r_dvsr))
    else $error("divider result outside DIV_DONE or remainder not reduced");

endmodule

/* design/muldiv_pipe.sv */
`include "muldiv_defines.svh"

module muldiv_pipe (
  input  logic                              i_clk,
  input  logic                              i_reset_n,
  input  logic                              i_valid,
  input  muldiv_pkg::op_t                   i_op,
  input  logic [`MULDIV_XLEN-1:0]           i_rs1,
  input  logic [`MULDIV_XLEN-1:0]           i_rs2,
  input  muldiv_pkg::tag_t                  i_rd_tag,
  input  muldiv_pkg::brmask_t               i_br_mask,
  input  logic                              i_kill_valid,
  input  logic [`MULDIV_KILL_IDX_W-1:0]     i_kill_idx,
  output logic                              o_stall,
  output logic                              o_valid,
  output logic [`MULDIV_XLEN-1:0]           o_res,
  output muldiv_pkg::tag_t                  o_rd_tag
);

  logic                     issue_kill;
  logic                     mul_valid;
  logic                     div_valid;
  logic                     div_ready;
  logic                     mul_out_valid;
  logic [`MULDIV_XLEN-1:0]  mul_out_res;
  muldiv_pkg::tag_t         mul_out_tag;
  logic                     div_out_valid;
  logic [`MULDIV_XLEN-1:0]  div_out_res;
  muldiv_pkg::tag_t         div_out_tag;

  // ============================================================
  // issue steering
  // ============================================================

  assign issue_kill = muldiv_pkg::is_killed(i_br_mask, i_kill_valid, i_kill_idx);
  assign mul_valid  = i_valid & ~issue_kill & muldiv_pkg::is_mul_op(i_op);
  assign div_valid  = i_valid & ~issue_kill & muldiv_pkg::is_div_op(i_op);

  assign o_stall = ~div_ready;

  muldiv_mul_pipe u_mul_pipe (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_valid      (mul_valid),
    .i_op         (i_op),
    .i_rs1        (i_rs1),
    .i_rs2        (i_rs2),
    .i_rd_tag     (i_rd_tag),
    .i_br_mask    (i_br_mask),
    .i_kill_valid (i_kill_valid),
    .i_kill_idx   (i_kill_idx),
    .o_valid      (mul_out_valid),
    .o_res        (mul_out_res),
    .o_rd_tag     (mul_out_tag)
  );

  muldiv_div_unit u_div_unit (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_valid      (div_valid),
    .i_op         (i_op),
    .i_rs1        (i_rs1),
    .i_rs2        (i_rs2),
    .i_rd_tag     (i_rd_tag),
    .i_br_mask    (i_br_mask),
    .i_kill_valid (i_kill_valid),
    .i_kill_idx   (i_kill_idx),
    .i_resp_ready (~mul_out_valid),     // multiplier owns the port
    .o_ready      (div_ready),
    .o_valid      (div_out_valid),
    .o_res        (div_out_res),
    .o_rd_tag     (div_out_tag)
  );

  // ============================================================
  // result port
  // ============================================================

  assign o_valid  = mul_out_valid | div_out_valid;
  assign o_res    = mul_out_valid ? mul_out_res : div_out_res;
  assign o_rd_tag = mul_out_valid ? mul_out_tag : div_out_tag;

  a_no_issue_when_stalled: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_valid |-> !o_stall)
    else $error("operation issued while o_stall high");

  a_single_result: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(mul_out_valid && div_out_valid))
    else $error("multiply and divide results in the same cycle");

endmodule

/* testbench/tb_clock_gen.sv */
module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 16,
  parameter int RELEASE_DLY  = 10
) (
  output logic o_clk,
  output logic o_reset_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  initial begin
    o_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #RELEASE_DLY;
    o_reset_n = 1'b1;                         // released just after an edge
  end

endmodule

/* testbench/tb_muldiv.sv */
`include "muldiv_defines.svh"

module tb_muldiv;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_VEC   = 40;
  localparam int FIELDS    = 8;               // op rs1 rs2 tag mask kill slot expected
  localparam int DRIVE_DLY = 10;
  localparam int NUM_TAGS  = 1 << `MULDIV_TAG_W;
  localparam int MUL_LAT   = 4;

  logic                           clk;
  logic                           reset_n;
  logic                           valid;
  muldiv_pkg::op_t                op;
  logic [`MULDIV_XLEN-1:0]        rs1;
  logic [`MULDIV_XLEN-1:0]        rs2;
  muldiv_pkg::tag_t               rd_tag;
  muldiv_pkg::brmask_t            br_mask;
  logic                           kill_valid;
  logic [`MULDIV_KILL_IDX_W-1:0]  kill_idx;
  logic                           stall;
  logic                           res_valid;
  logic [`MULDIV_XLEN-1:0]        res;
  muldiv_pkg::tag_t               res_tag;

  logic [31:0]                    vec_mem [0:MAX_VEC*FIELDS-1];
  logic [`MULDIV_XLEN-1:0]        exp_res [NUM_TAGS];
  bit                             pending [NUM_TAGS];
  bit                             seen    [NUM_TAGS];
  bit                             is_mul  [NUM_TAGS];
  int                             issue_cyc [NUM_TAGS];
  int                             vec_of_tag [NUM_TAGS];
  int                             num_vec = 0;
  int                             cycle = 0;
  int                             errors = 0;
  int                             passed = 0;
  int                             failed = 0;
  int                             killed = 0;
  int                             outstanding = 0;
  int                             kill_wait = 0;
  logic [`MULDIV_KILL_IDX_W-1:0]  kill_slot;
  bit                             loaded = 1'b0;
  bit                             stall_release = 1'b0;

  tb_clock_gen clk_gen_i (
    .o_clk     (clk),
    .o_reset_n (reset_n)
  );

  muldiv_pipe dut_i (
    .i_clk        (clk),
    .i_reset_n    (reset_n),
    .i_valid      (valid),
    .i_op         (op),
    .i_rs1        (rs1),
    .i_rs2        (rs2),
    .i_rd_tag     (rd_tag),
    .i_br_mask    (br_mask),
    .i_kill_valid (kill_valid),
    .i_kill_idx   (kill_idx),
    .o_stall      (stall),
    .o_valid      (res_valid),
    .o_res        (res),
    .o_rd_tag     (res_tag)
  );

  always @(posedge clk) cycle++;

  // ============================================================
  // stimulus
  // ============================================================

  // advance to the drive point of the next cycle, fire a delayed kill
  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
    valid      = 1'b0;
    kill_valid = 1'b0;
    if (kill_wait > 0) begin
      kill_wait--;
      if (kill_wait == 0) begin
        kill_valid = 1'b1;
        kill_idx   = kill_slot;
      end
    end
  endtask

  task automatic issue_vector(input int idx);
    int               base;
    muldiv_pkg::tag_t t;
    base    = idx * FIELDS;
    t       = vec_mem[base+3][`MULDIV_TAG_W-1:0];
    valid   = 1'b1;
    op      = muldiv_pkg::op_t'(vec_mem[base][3:0]);
    rs1     = vec_mem[base+1];
    rs2     = vec_mem[base+2];
    rd_tag  = t;
    br_mask = vec_mem[base+4][`MULDIV_BRMASK_W-1:0];
    if (vec_mem[base+5] == 32'd1) begin       // kill in the issue cycle
      kill_valid = 1'b1;
      kill_idx   = vec_mem[base+6][`MULDIV_KILL_IDX_W-1:0];
    end else if (vec_mem[base+5] > 32'd1) begin
      kill_wait = int'(vec_mem[base+5]) - 1;
      kill_slot = vec_mem[base+6][`MULDIV_KILL_IDX_W-1:0];
    end
    if (vec_mem[base+5] == 32'd0) begin
      pending[t]   = 1'b1;
      exp_res[t]   = vec_mem[base+7];
      outstanding++;
    end
    issue_cyc[t]  = cycle;
    is_mul[t]     = (vec_mem[base] >= 32'd1) && (vec_mem[base] <= 32'd4);
    vec_of_tag[t] = idx;
    if (!is_mul[t] && vec_mem[base+5] == 32'd0) begin
      next_cycle();
      if (!stall) begin
        $display("CHECK FAILED at %0t: o_stall low after divide tag %0d", $time, t);
        errors++;
      end
    end
  endtask

  // ============================================================
  // checking
  // ============================================================

  task automatic check_result();
    bit ok;
    ok = 1'b1;
    seen[res_tag] = 1'b1;
    if (!pending[res_tag]) begin
      $display("unexpected result for tag %0d at %0t", res_tag, $time);
      errors++;
      return;
    end
    pending[res_tag] = 1'b0;
    outstanding--;
    stall_release = !is_mul[res_tag];
    if (res !== exp_res[res_tag]) begin
      $display("CHECK FAILED at %0t: tag %0d result %h, expected %h", $time, res_tag, res,
               exp_res[res_tag]);
      ok = 1'b0;
    end
    if (is_mul[res_tag] && (cycle - issue_cyc[res_tag]) != MUL_LAT) begin
      $display("CHECK FAILED at %0t: tag %0d latency %0d, expected %0d", $time, res_tag,
               cycle - issue_cyc[res_tag], MUL_LAT);
      ok = 1'b0;
    end
    if (ok) begin
      passed++;
    end else begin
      failed++;
      errors++;
    end
    $display("test %0d tag %0d: %s", vec_of_tag[res_tag], res_tag, ok ? "ok" : "failed");
  endtask

  always @(negedge clk) begin
    if (!reset_n && (res_valid || stall)) begin
      $display("CHECK FAILED at %0t: o_valid %b o_stall %b in reset", $time, res_valid, stall);
      errors++;
    end
    if (stall_release) begin
      stall_release = 1'b0;
      if (stall) begin
        $display("CHECK FAILED at %0t: o_stall still high after divide result", $time);
        errors++;
      end
    end
    if (reset_n && res_valid) begin
      check_result();
    end
  end

  task automatic report_killed();
    muldiv_pkg::tag_t t;
    for (int i = 0; i < num_vec; i++) begin
      t = vec_mem[i*FIELDS+3][`MULDIV_TAG_W-1:0];
      if (vec_mem[i*FIELDS+5] != 32'd0) begin
        if (seen[t]) begin
          failed++;
          $display("test %0d tag %0d: killed op still produced a result", i, t);
        end else begin
          killed++;
          $display("test %0d tag %0d: killed, no result", i, t);
        end
      end
    end
  endtask

  initial begin : drive
    int gap;
    valid      = 1'b0;
    op         = muldiv_pkg::OP_NONE;
    rs1        = '0;
    rs2        = '0;
    rd_tag     = '0;
    br_mask    = '0;
    kill_valid = 1'b0;
    kill_idx   = '0;
    void'($urandom(32'h7d2f_7d6a));
    for (int i = 0; i < MAX_VEC*FIELDS; i++) begin
      vec_mem[i] = 32'hffff_ffff;             // unused slots read as end marker
    end
    $readmemh("testbench/muldiv_input.txt", vec_mem);
    while (num_vec < MAX_VEC && vec_mem[num_vec*FIELDS] != 32'hffff_ffff) num_vec++;
    loaded = 1'b1;
    if (num_vec == 0) begin
      $display("no vectors were read from the input file");
      errors++;
    end
    wait (reset_n);
    for (int i = 0; i < num_vec; i++) begin
      gap = ($urandom % 8 == 0) ? int'(1 + $urandom % 2) : 0;
      repeat (gap) next_cycle();
      next_cycle();
      while (stall) next_cycle();
      issue_vector(i);
    end
    while (outstanding > 0) next_cycle();
    repeat (8) next_cycle();                   // catch late stray results
    report_killed();
    $display("tests %0d: passed %0d, failed %0d, killed %0d, errors %0d", num_vec, passed,
             failed, killed, errors);
    if (errors == 0 && failed == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    wait (loaded);
    repeat (num_vec * (`MULDIV_XLEN + 8) + 16) @(posedge clk);
    $display("timeout: the run did not finish in time, %0d results still missing", outstanding);
    $display(">>> FAIL");
    $finish;
  end

endmodule

/* testbench/muldiv_input.txt */
// op rs1 rs2 tag br_mask kill slot expected (hex)
// kill 0 none, 1 in issue cycle, n pulses n-1 cycles after issue
1 00000007 00000006 01 1 0 0 0000002a
1 fffffffd 00000005 02 1 0 0 fffffff1
2 80000000 80000000 03 1 0 0 40000000
2 ffffffff 00000002 04 1 0 0 ffffffff
4 ffffffff ffffffff 05 1 0 0 fffffffe
3 ffffffff ffffffff 06 1 0 0 ffffffff
3 00000002 ffffffff 07 1 0 0 00000001
4 12345678 00010000 08 1 0 0 00001234
5 fffffff9 00000002 09 1 0 0 fffffffd
7 fffffff9 00000002 0a 1 0 0 ffffffff
6 fffffff9 00000002 0b 1 0 0 7ffffffc
8 00000064 00000007 0c 1 0 0 00000002
5 00000005 00000000 0d 1 0 0 ffffffff
7 00000005 00000000 0e 1 0 0 00000005
5 80000000 ffffffff 0f 1 0 0 80000000
7 80000000 ffffffff 10 1 0 0 00000000
7 00000007 fffffffe 11 1 0 0 00000001
1 0000000b 0000000b 12 1 0 0 00000079
4 80000000 00000004 13 1 0 0 00000002
6 0000000a 00000000 14 1 0 0 ffffffff
1 0000002a 00000002 15 2 1 1 00000000
1 00000003 00000003 16 1 0 0 00000009
1 00000004 00000004 17 4 3 2 00000000
1 00000005 00000005 18 1 0 0 00000019
6 00000064 00000005 19 1 0 0 00000014
5 00000064 00000005 1a 8 3 3 00000000
1 00000006 00000007 1b 8 5 3 00000000
8 0000000a 00000003 1c 1 0 0 00000001

/* list.f */
+incdir+design
design/muldiv_pkg.sv
design/muldiv_mul_pipe.sv
design/muldiv_div_unit.sv
design/muldiv_pipe.sv
testbench/tb_clock_gen.sv
testbench/tb_muldiv.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the muldiv testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_muldiv \
  --Mdir obj_dir -o sim_muldiv

./obj_dir/sim_muldiv | tee sim.log

if grep -q '^>>> FAIL$' sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
